// File: include/riscv_io_config.svh
`ifndef RISCV_IO_CONFIG_SVH
`define RISCV_IO_CONFIG_SVH

// transmit FIFO, kept small so full is reached quickly
`define RIO_FIFO_DEPTH 4

// clock cycles per serial bit after reset
`define RIO_BAUD_DIV_RST 16'd4

// parity off, even type
`define RIO_PAR_EN_RST   1'b0
`define RIO_PAR_TYPE_RST 1'b0

// cycles the sampled button must hold a new level
`define RIO_DEBOUNCE_CYCLES 8

`endif

// File: hw/riscv_io_pkg.sv
`default_nettype none

package riscv_io_pkg;

  // one core write strobe
  typedef struct packed {
    logic [1:0] addr;
    logic [7:0] data;
  } io_wr_t;

  // UART frame setup
  typedef struct packed {
    logic [15:0] baud_div;  // cycles per bit, 2 or more
    logic        par_en;
    logic        par_type;  // 0 even, 1 odd
  } uart_cfg_t;

  // register map
  localparam logic [1:0] REG_TX_DATA = 2'd0;
  localparam logic [1:0] REG_BAUD_LO = 2'd1;
  localparam logic [1:0] REG_BAUD_HI = 2'd2;
  localparam logic [1:0] REG_CTRL    = 2'd3;  // bit 0 parity enable, bit 1 parity type

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } tx_state_t;

endpackage

`default_nettype wire

// File: hw/riscv_button_debouncer.sv
`timescale 1ns/100ps
`default_nettype none

`include "riscv_io_config.svh"

module riscv_button_debouncer (
  input  logic i_riscv_clk,
  input  logic i_reset    ,
  input  logic i_noisy    ,
  output logic o_debounced
);

  localparam int CYCLES = `RIO_DEBOUNCE_CYCLES;
  localparam int CNT_W  = $clog2(CYCLES + 1);

  logic             sync_q1;
  logic             sync_q2;
  logic [CNT_W-1:0] stable_cnt;

  // button is asynchronous to the core clock
  always_ff @(posedge i_riscv_clk) begin
    if (i_reset) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= i_noisy;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (i_reset) begin
      stable_cnt  <= '0;
      o_debounced <= 1'b0;
    end else if (sync_q2 == o_debounced) begin
      stable_cnt <= '0;  // bounced back, start over
    end else if (stable_cnt == CNT_W'(CYCLES - 1)) begin
      // new level held long enough
      stable_cnt  <= '0;
      o_debounced <= sync_q2;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "riscv_io_config.svh"

module uart_cfg_regs (
  input  logic                    i_riscv_clk,
  input  logic                    i_reset    ,
  input  logic                    i_wr       ,
  input  riscv_io_pkg::io_wr_t    i_wr_req   ,
  output riscv_io_pkg::uart_cfg_t o_cfg      ,
  output logic                    o_push     ,
  output logic [7:0]              o_push_data
);

  import riscv_io_pkg::*;

  // configuration registers
  always_ff @(posedge i_riscv_clk) begin
    if (i_reset) begin
      o_cfg.baud_div <= `RIO_BAUD_DIV_RST;
      o_cfg.par_en   <= `RIO_PAR_EN_RST;
      o_cfg.par_type <= `RIO_PAR_TYPE_RST;
    end else if (i_wr) begin
      case (i_wr_req.addr)
        REG_BAUD_LO: o_cfg.baud_div[7:0]  <= i_wr_req.data;
        REG_BAUD_HI: o_cfg.baud_div[15:8] <= i_wr_req.data;
        REG_CTRL: begin
          o_cfg.par_en   <= i_wr_req.data[0];
          o_cfg.par_type <= i_wr_req.data[1];
        end
        default: ;  // data writes go to the FIFO
      endcase
    end
  end

  // FIFO decides whether the byte fits
  assign o_push      = i_wr && (i_wr_req.addr == REG_TX_DATA);
  assign o_push_data = i_wr_req.data;

endmodule

`default_nettype wire

// File: hw/uart_tx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "riscv_io_config.svh"

module uart_tx_fifo (
  input  logic       i_riscv_clk,
  input  logic       i_reset    ,
  input  logic       i_push     ,
  input  logic       i_pop      ,
  input  logic [7:0] i_push_data,
  output logic [7:0] o_rd_data  ,
  output logic       o_empty    ,
  output logic       o_full
);

  localparam int DEPTH = `RIO_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push_ok;
  logic          pop_ok;

  assign push_ok = i_push && !o_full;  // overflow is dropped
  assign pop_ok  = i_pop && !o_empty;

  always_ff @(posedge i_riscv_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge i_riscv_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  assign o_rd_data = mem[rd_ptr];  // head shown without delay
  assign o_empty   = (count == '0);
  assign o_full    = (count == (AW+1)'(DEPTH));

endmodule

`default_nettype wire

// File: hw/uart_tx_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_serializer (
  input  logic                    i_riscv_clk,
  input  logic                    i_reset    ,
  input  riscv_io_pkg::uart_cfg_t i_cfg      ,
  input  logic                    i_empty    ,
  input  logic [7:0]              i_rd_data  ,
  output logic                    o_pop      ,
  output logic                    o_tx       ,
  output logic                    o_busy
);

  import riscv_io_pkg::*;

  tx_state_t   state;
  logic [15:0] baud_cnt;
  logic [15:0] baud_div_q;  // divisor of the frame in flight
  logic        par_en_q;
  logic        par_bit_q;
  logic [2:0]  bit_idx;
  logic [7:0]  shift_q;
  logic        bit_end;

  assign bit_end = (baud_cnt == baud_div_q - 16'd1);

  // last stop cycle may pop too, frames then run back to back
  assign o_pop = !i_empty && ((state == IDLE) || ((state == STOP) && bit_end));

  always_ff @(posedge i_riscv_clk) begin
    if (i_reset) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (o_pop) begin
      state    <= START;
      baud_cnt <= '0;
    end else if (state != IDLE) begin
      if (bit_end) begin
        baud_cnt <= '0;
        case (state)
          START: begin
            state   <= DATA;
            bit_idx <= '0;
          end
          DATA: begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= par_en_q ? PARITY : STOP;
            end
          end
          PARITY:  state <= STOP;
          default: state <= IDLE;  // stop bit done, nothing waiting
        endcase
      end else begin
        baud_cnt <= baud_cnt + 16'd1;
      end
    end
  end

  // byte and setup captured at pop
  always_ff @(posedge i_riscv_clk) begin
    if (o_pop) begin
      shift_q    <= i_rd_data;
      baud_div_q <= i_cfg.baud_div;
      par_en_q   <= i_cfg.par_en;
      par_bit_q  <= (^i_rd_data) ^ i_cfg.par_type;  // odd inverts
    end else if ((state == DATA) && bit_end) begin
      shift_q <= shift_q >> 1;  // LSB first
    end
  end

  always_comb begin
    case (state)
      START:   o_tx = 1'b0;
      DATA:    o_tx = shift_q[0];
      PARITY:  o_tx = par_bit_q;
      default: o_tx = 1'b1;  // stop and idle
    endcase
  end

  assign o_busy = (state != IDLE);

endmodule

`default_nettype wire

// File: hw/riscv_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_io_top (
  input  logic                 i_riscv_clk                   ,
  input  logic                 i_reset                       ,
  input  logic                 i_wr                          ,
  input  riscv_io_pkg::io_wr_t i_wr_req                      ,
  input  logic                 i_riscv_top_external_interrupt,
  output logic                 o_riscv_top_tx_data           ,
  output logic                 o_riscv_top_tx_busy           ,
  output logic                 o_tx_fifo_full                ,
  output logic                 o_ext_irq
);

  import riscv_io_pkg::*;

  uart_cfg_t  cfg;
  logic       push;
  logic [7:0] push_data;
  logic       pop;
  logic [7:0] fifo_rd_data;
  logic       fifo_empty;

  uart_cfg_regs u_cfg_regs (
    .i_riscv_clk(i_riscv_clk),
    .i_reset    (i_reset    ),
    .i_wr       (i_wr       ),
    .i_wr_req   (i_wr_req   ),
    .o_cfg      (cfg        ),
    .o_push     (push       ),
    .o_push_data(push_data  )
  );

  uart_tx_fifo u_tx_fifo (
    .i_riscv_clk(i_riscv_clk   ),
    .i_reset    (i_reset       ),
    .i_push     (push          ),
    .i_pop      (pop           ),
    .i_push_data(push_data     ),
    .o_rd_data  (fifo_rd_data  ),
    .o_empty    (fifo_empty    ),
    .o_full     (o_tx_fifo_full)  // polled by the core
  );

  uart_tx_serializer u_tx_serializer (
    .i_riscv_clk(i_riscv_clk        ),
    .i_reset    (i_reset            ),
    .i_cfg      (cfg                ),
    .i_empty    (fifo_empty         ),
    .i_rd_data  (fifo_rd_data       ),
    .o_pop      (pop                ),
    .o_tx       (o_riscv_top_tx_data),
    .o_busy     (o_riscv_top_tx_busy)
  );

  riscv_button_debouncer u_button_debouncer (
    .i_riscv_clk(i_riscv_clk                   ),
    .i_reset    (i_reset                       ),
    .i_noisy    (i_riscv_top_external_interrupt),
    .o_debounced(o_ext_irq                     )
  );

endmodule

`default_nettype wire

// File: test/riscv_io_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_io_asserts (
  input logic i_riscv_clk,
  input logic i_reset,
  input logic i_tx,
  input logic i_busy,
  input logic i_full,
  input logic i_irq,
  input logic i_pop
);

  // idle line stays a mark until a pop starts a frame
  idle_line_high: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
    (!i_busy && !i_pop) |=> (!i_busy && i_tx))
    else $error("serial line left idle without a pop");

  // start bit begins on the edge that takes the pop
  pop_starts_frame: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
    i_pop |=> (i_busy && !i_tx))
    else $error("no start bit after a pop");

  reset_outputs: assert property (@(posedge i_riscv_clk)
    i_reset |=> (i_tx && !i_busy && !i_full && !i_irq))
    else $error("outputs active right after reset");

endmodule

bind riscv_io_top riscv_io_asserts u_asserts (
  .i_riscv_clk(i_riscv_clk),
  .i_reset    (i_reset),
  .i_tx       (o_riscv_top_tx_data),
  .i_busy     (o_riscv_top_tx_busy),
  .i_full     (o_tx_fifo_full),
  .i_irq      (o_ext_irq),
  .i_pop      (pop)
);

`default_nettype wire

// File: test/riscv_io_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "riscv_io_config.svh"

module riscv_io_tb;

  import riscv_io_pkg::*;

  logic        clk;
  logic        rst;
  logic        wr;
  io_wr_t      wr_req;
  logic        btn;
  logic        tx;
  logic        busy;
  logic        full;
  logic        irq;
  logic [15:0] m_div;  // divisor the decoder expects
  logic        m_pen;
  logic        m_ptype;
  logic [7:0]  rx_bytes[$];
  logic        rx_ok[$];
  int          errors;

  riscv_io_top dut0 (
    .i_riscv_clk                   (clk),
    .i_reset                       (rst),
    .i_wr                          (wr),
    .i_wr_req                      (wr_req),
    .i_riscv_top_external_interrupt(btn),
    .o_riscv_top_tx_data           (tx),
    .o_riscv_top_tx_busy           (busy),
    .o_tx_fifo_full                (full),
    .o_ext_irq                     (irq)
  );

  always #10 clk = ~clk;

  task automatic check(input int got, input int exp, input string msg);
    if (got != exp) begin
      $display("FAILED t=%0t %s: got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // every cycle of a bit slot is sampled on the falling edge
  always begin : frame_decoder
    int          div;
    int          nslots;
    logic        ptype;
    logic        first;
    logic [10:0] slot;  // start, 8 data, parity if enabled, stop
    logic        ok;
    @(negedge clk);
    if (!rst && tx === 1'b0) begin
      div    = int'(m_div);
      nslots = m_pen ? 11 : 10;
      ptype  = m_ptype;
      ok     = 1'b1;
      slot   = '0;
      first  = 1'b0;
      for (int s = 0; s < nslots; s++) begin
        for (int c = 0; c < div; c++) begin
          if (s != 0 || c != 0) @(negedge clk);
          if (c == 0) first = tx;
          if (c == div / 2) slot[s] = tx;  // bit centre
          if (tx !== first) ok = 1'b0;  // edge inside a bit slot
          if (busy !== 1'b1) ok = 1'b0;
        end
      end
      if (slot[nslots-1] !== 1'b1) ok = 1'b0;  // stop bit
      if (nslots == 11 && slot[9] !== ((^slot[8:1]) ^ ptype)) ok = 1'b0;
      rx_bytes.push_back(slot[8:1]);
      rx_ok.push_back(ok);
    end
  end

  initial begin
    reg [639:0] lines[0:127];
    reg [639:0] line;
    reg [127:0] cmd;
    reg [127:0] name;
    int         fd;
    int         nlines;
    int         a;
    int         b;
    int         nframes;
    int         pcycles;
    int         maxdiv;
    int         lim;
    int         tests;
    int         bad_tests;
    int         test_err;
    logic [15:0] div_p;
    clk = 1'b0;
    rst = 1'b1;
    wr = 1'b0;
    wr_req = '0;
    btn = 1'b0;
    m_div = `RIO_BAUD_DIV_RST;
    m_pen = `RIO_PAR_EN_RST;
    m_ptype = `RIO_PAR_TYPE_RST;
    errors = 0;
    nlines = 0;
    nframes = 0;
    pcycles = 0;
    tests = 0;
    bad_tests = 0;
    div_p = `RIO_BAUD_DIV_RST;
    maxdiv = int'(div_p);
    a = $urandom(2);
    fd = $fopen("test/riscv_io_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file test/riscv_io_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          lines[nlines] = line;
          nlines++;
          cmd = '0;
          void'($sscanf(line, "%s %h %h", cmd, a, b));
          if (cmd == "E") nframes++;
          if (cmd == "P") pcycles += b;
          if (cmd == "W" && a == 1) div_p[7:0] = b[7:0];
          if (cmd == "W" && a == 2) div_p[15:8] = b[7:0];
          if (int'(div_p) > maxdiv) maxdiv = int'(div_p);
        end
      end
      $fclose(fd);
    end

    // every expected frame at the longest frame, plus button time and slack
    lim = ((nframes + 2) * 11 * maxdiv + pcycles + 600) * 20;
    fork
      begin
        #(lim);
        $display("timeout: the run did not finish in %0d ns", lim);
        $display("Regression failed");
        $finish;
      end
    join_none

    test_err = errors;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check(tx, 1, "line after reset");
    check(busy, 0, "busy after reset");
    check(full, 0, "fifo_full after reset");
    check(irq, 0, "irq after reset");
    tests++;
    if (errors != test_err) bad_tests++;
    $display("test reset: %s", (errors == test_err) ? "ok" : "FAILED");
    test_err = errors;

    for (int i = 0; i < nlines; i++) begin
      cmd = '0;
      void'($sscanf(lines[i], "%s %h %h", cmd, a, b));
      if (cmd == "W") begin
        repeat ($urandom_range(0, 2)) @(posedge clk);  // idle gap
        @(posedge clk);
        wr <= 1'b1;
        wr_req <= '{addr: a[1:0], data: b[7:0]};
        @(posedge clk);
        wr <= 1'b0;
        case (a[1:0])
          REG_BAUD_LO: m_div[7:0] = b[7:0];
          REG_BAUD_HI: m_div[15:8] = b[7:0];
          REG_CTRL: begin
            m_pen = b[0];
            m_ptype = b[1];
          end
          default: ;
        endcase
      end else if (cmd == "E") begin
        while (rx_bytes.size() == 0) @(negedge clk);
        check(rx_bytes.pop_front(), a, "received byte");
        check(rx_ok.pop_front(), 1, "frame timing, parity, stop bit or busy");
      end else if (cmd == "P") begin
        @(posedge clk);
        btn <= a[0];
        repeat (b) @(posedge clk);
      end else if (cmd == "L") begin
        @(negedge clk);
        check(irq, a, "ext_irq level");
      end else if (cmd == "F") begin
        @(negedge clk);
        check(full, a, "fifo_full level");
      end else if (cmd == "T") begin
        name = '0;
        void'($sscanf(lines[i], "%s %s", cmd, name));
        tests++;
        if (errors != test_err) bad_tests++;
        $display("test %0s: %s", name, (errors == test_err) ? "ok" : "FAILED");
        test_err = errors;
      end
    end

    repeat (200) @(posedge clk);
    check(rx_bytes.size(), 0, "frames left over");
    $display("tests %0d, failed tests %0d, errors %0d", tests, bad_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: riscv_io.f
+incdir+include
hw/riscv_io_pkg.sv
hw/riscv_button_debouncer.sv
hw/uart_cfg_regs.sv
hw/uart_tx_fifo.sv
hw/uart_tx_serializer.sv
hw/riscv_io_top.sv
test/riscv_io_asserts.sv
test/riscv_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= riscv_io_tb
FILELIST  ?= riscv_io.f
PASS_MSG  := Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: test/riscv_io_stim.txt
# cmd args, numbers in hex: W addr data | E byte | P level cycles
# L irq_level | F fifo_full_level | T test_name
W 0 a5
W 0 3c
E a5
E 3c
T default
W 3 01
W 0 96
E 96
W 3 03
W 0 97
E 97
T parity
W 1 07
W 2 00
W 0 5a
E 5a
T baud
W 3 00
W 1 04
W 0 11
W 0 22
W 0 33
W 0 44
W 0 55
W 0 66
F 1
E 11
E 22
E 33
E 44
E 55
F 0
T overflow
P 1 04
P 0 14
L 0
P 1 0e
L 1
P 0 0e
L 0
T debounce
